//--- files.f
logic/mips_isa_pkg.sv
logic/mips_ctrl_pkg.sv
logic/mips_main_decoder.sv
logic/mips_alu_decoder.sv
logic/mips_controller.sv
logic/mips_regfile.sv
logic/mips_alu.sv
logic/mips_datapath.sv
logic/mips_cpu_harvard.sv
sim/mips_cpu_props.sv
sim/mips_cpu_tb.sv

//--- Bender.yml
package:
  name: mips_cpu_harvard

sources:
  - target: rtl
    files:
      - logic/mips_isa_pkg.sv
      - logic/mips_ctrl_pkg.sv
      - logic/mips_main_decoder.sv
      - logic/mips_alu_decoder.sv
      - logic/mips_controller.sv
      - logic/mips_regfile.sv
      - logic/mips_alu.sv
      - logic/mips_datapath.sv
      - logic/mips_cpu_harvard.sv
  - target: simulation
    files:
      - sim/mips_cpu_props.sv
      - sim/mips_cpu_tb.sv

//--- sim/mips_cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mips_cpu_tb;

	localparam logic [31:0] RESET_VECTOR = 32'h0000_0040;
	localparam int PROG_LEN   = 200;
	localparam int PROG_BASE  = RESET_VECTOR / 4; // First program word
	localparam int LAST_WORD  = PROG_BASE + PROG_LEN - 1; // Holds J 0
	localparam int CLK_PERIOD = 4;
	localparam int TIMEOUT_NS = (PROG_LEN * 4 + 14) * CLK_PERIOD; // Stalls plus reset and tail

	logic clk = 1'b0;
	logic reset, clk_enable, active;
	logic [31:0] register_v0, instr_address, instr_readdata;
	logic [31:0] data_address, data_writedata, data_readdata;
	logic data_write, data_read;

	logic [31:0] imem [256];
	logic [31:0] dmem [64]; // Memory seen by the DUT
	int seed = 18858;

	logic [31:0] m_pc; // Reference model state
	logic m_active;
	logic [31:0] m_regs [32];
	logic [31:0] m_dmem [64];

	logic hold_expected; // Previous edge was a stall
	logic [31:0] prev_pc, prev_v0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	mips_cpu_harvard #(
		.RESET_VECTOR (RESET_VECTOR)
	) UUT (
		.clk            (clk),
		.reset          (reset),
		.clk_enable     (clk_enable),
		.active         (active),
		.register_v0    (register_v0),
		.instr_address  (instr_address),
		.instr_readdata (instr_readdata),
		.data_address   (data_address),
		.data_write     (data_write),
		.data_read      (data_read),
		.data_writedata (data_writedata),
		.data_readdata  (data_readdata)
	);

	// Same-cycle memories
	assign instr_readdata = imem[instr_address[9:2]];
	assign data_readdata  = dmem[data_address[7:2]];

	function automatic int rand_below(int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [31:0] data_fill(int idx);
		return 32'h1357_9bdf + idx * 32'h0404_1011; // Distinct per word
	endfunction

	task automatic fail_run();
		$display("SIMULATION FAILED");
		$fatal(1, "Stopped at first mismatch");
	endtask

	task automatic compare_word(string name, logic [31:0] got, logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERROR: %s is 0x%h, expected 0x%h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic build_program();
		int rs, rt, rd, kind, off, tgt;
		logic [5:0] fn;
		for (int a = 0; a < 256; a++) begin
			imem[a] = {6'h3f, 18'h0, a[7:0]}; // Unused opcode, never reached
		end
		for (int k = PROG_BASE; k < LAST_WORD; k++) begin
			rs = 1 + rand_below(7);
			rt = 1 + rand_below(7);
			rd = 1 + rand_below(7);
			kind = (k == PROG_BASE) ? 11 : rand_below(16); // Store sits at the reset vector
			if (kind < 6) begin
				case (rand_below(5))
					0: fn = mips_isa_pkg::FN_ADD;
					1: fn = mips_isa_pkg::FN_SUB;
					2: fn = mips_isa_pkg::FN_AND;
					3: fn = mips_isa_pkg::FN_OR;
					default: fn = mips_isa_pkg::FN_SLT;
				endcase
				imem[k] = {mips_isa_pkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
			end else if (kind < 9) begin
				imem[k] = {mips_isa_pkg::OP_ADDI, 5'(rs), 5'(rt), 16'(rand_below(65536))};
			end else if (kind < 11) begin
				imem[k] = {mips_isa_pkg::OP_LW, 5'd0, 5'(rt), 16'(4 * rand_below(64))};
			end else if (kind < 13) begin
				imem[k] = {mips_isa_pkg::OP_SW, 5'd0, 5'(rt), 16'(4 * rand_below(64))};
			end else if (kind < 15) begin
				if (kind == 14) rt = rs; // Always taken
				off = 1 + rand_below(4);
				if (k + 1 + off > LAST_WORD) off = LAST_WORD - k - 1; // Stay inside program
				imem[k] = {mips_isa_pkg::OP_BEQ, 5'(rs), 5'(rt), 16'(off)};
			end else begin
				tgt = k + 1 + rand_below(8); // Forward only
				if (tgt > LAST_WORD) tgt = LAST_WORD;
				imem[k] = {mips_isa_pkg::OP_J, 26'(tgt)};
			end
		end
		imem[LAST_WORD] = {mips_isa_pkg::OP_J, 26'd0}; // Halt
	endtask

	task automatic model_reset();
		m_pc = RESET_VECTOR;
		m_active = 1'b1;
		for (int i = 0; i < 32; i++) begin
			m_regs[i] = '0;
		end
		for (int i = 0; i < 64; i++) begin
			dmem[i]   = data_fill(i);
			m_dmem[i] = data_fill(i);
		end
	endtask

	// One instruction of the ISA model
	task automatic model_step();
		logic [31:0] ins, a, b, sext, addr, next_pc, res, tgt;
		ins  = imem[m_pc[9:2]];
		a    = m_regs[ins[25:21]];
		b    = m_regs[ins[20:16]];
		sext = {{16{ins[15]}}, ins[15:0]};
		addr = a + sext; // Also the ADDI sum
		next_pc = m_pc + 32'd4;
		case (ins[31:26])
			mips_isa_pkg::OP_RTYPE: begin
				case (ins[5:0])
					mips_isa_pkg::FN_SUB: res = a - b;
					mips_isa_pkg::FN_AND: res = a & b;
					mips_isa_pkg::FN_OR:  res = a | b;
					mips_isa_pkg::FN_SLT: res = {31'd0, $signed(a) < $signed(b)};
					default:              res = a + b;
				endcase
				if (ins[15:11] != 5'd0) m_regs[ins[15:11]] = res;
			end
			mips_isa_pkg::OP_LW: if (ins[20:16] != 5'd0) m_regs[ins[20:16]] = m_dmem[addr[7:2]];
			mips_isa_pkg::OP_SW: m_dmem[addr[7:2]] = b;
			mips_isa_pkg::OP_BEQ: if (a == b) next_pc = next_pc + {sext[29:0], 2'b00};
			mips_isa_pkg::OP_ADDI: if (ins[20:16] != 5'd0) m_regs[ins[20:16]] = addr;
			mips_isa_pkg::OP_J: begin
				tgt = {next_pc[31:28], ins[25:0], 2'b00};
				if (tgt == 32'd0) begin
					m_active = 1'b0; // PC parks on the J 0
					next_pc  = m_pc;
				end else begin
					next_pc = tgt;
				end
			end
			default: ;
		endcase
		m_pc = next_pc;
	endtask

	// Stall pattern, DUT memory write and model step on each edge
	always @(posedge clk) begin
		hold_expected <= !reset && !clk_enable;
		if (reset) clk_enable <= 1'b0;
		else clk_enable <= (rand_below(4) != 0); // Roughly one stall in four
		if (!reset && clk_enable && data_write) dmem[data_address[7:2]] <= data_writedata;
		if (!reset && clk_enable && m_active) model_step();
	end

	// Outputs compared mid-cycle where they are settled
	always @(negedge clk) begin
		logic [31:0] ins, exp_addr;
		if (!reset) begin
			assert (UUT.u_props.error_count == 0) else begin
				$display("A bound property on the core ports failed");
				fail_run();
			end
			ins = imem[m_pc[9:2]];
			exp_addr = m_regs[ins[25:21]] + {{16{ins[15]}}, ins[15:0]};
			compare_word("instr_address", instr_address, m_pc);
			compare_word("active", active, m_active);
			compare_word("register_v0", register_v0, m_regs[mips_isa_pkg::REG_V0]);
			compare_word("data_write", data_write,
				m_active && ins[31:26] == mips_isa_pkg::OP_SW);
			compare_word("data_read", data_read, m_active && ins[31:26] == mips_isa_pkg::OP_LW);
			if (data_write) begin
				compare_word("data_address", data_address, exp_addr);
				compare_word("data_writedata", data_writedata, m_regs[ins[20:16]]);
			end
			if (data_read) compare_word("data_address", data_address, exp_addr);
			if (hold_expected) begin
				compare_word("instr_address", instr_address, prev_pc); // Frozen by stall
				compare_word("register_v0", register_v0, prev_v0);
			end
			prev_pc = instr_address;
			prev_v0 = register_v0;
		end
	end

	initial begin
		reset = 1'b1;
		clk_enable = 1'b0;
		hold_expected = 1'b0;
		build_program();
		model_reset();
		repeat (3) @(posedge clk);
		@(negedge clk);
		compare_word("instr_address", instr_address, RESET_VECTOR); // Reset state
		compare_word("active", active, 32'd1);
		compare_word("register_v0", register_v0, 32'd0);
		compare_word("data_write", data_write, 32'd0); // Strobes held off in reset
		compare_word("data_read", data_read, 32'd0);
		@(posedge clk);
		reset <= 1'b0; // Fourth edge ends reset
		wait (!active);
		repeat (8) @(posedge clk); // Must stay parked
		@(negedge clk);
		if (UUT.u_props.error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the core did not halt on J 0 within %0d ns", TIMEOUT_NS);
		$display("SIMULATION FAILED");
		$fatal(1, "Watchdog expired");
	end

endmodule

`default_nettype wire

//--- sim/mips_cpu_props.sv
`timescale 1ns/1ns
`default_nettype none

module mips_cpu_props (
	input logic clk,
	input logic reset,
	input logic clk_enable,
	input logic active,
	input logic data_read,
	input logic data_write,
	input logic [31:0] instr_address
);

	int error_count = 0; // Property failures so far

	// At most one data access per cycle
	no_read_write_overlap: assert property (@(posedge clk) disable iff (reset)
		!(data_read && data_write))
		else begin
			error_count++;
			$error("data_read and data_write high in the same cycle");
		end

	// Halted core keeps the data bus quiet
	quiet_when_halted: assert property (@(posedge clk) disable iff (reset)
		!active |-> (!data_read && !data_write))
		else begin
			error_count++;
			$error("data bus strobe seen while core is halted");
		end

	// Stall edge leaves the fetch address alone
	stall_holds_pc: assert property (@(posedge clk) disable iff (reset)
		!clk_enable |=> $stable(instr_address))
		else begin
			error_count++;
			$error("instr_address moved across a stalled cycle");
		end

endmodule

bind mips_cpu_harvard mips_cpu_props u_props (
	.clk           (clk),
	.reset         (reset),
	.clk_enable    (clk_enable),
	.active        (active),
	.data_read     (data_read),
	.data_write    (data_write),
	.instr_address (instr_address)
);

`default_nettype wire

//--- logic/mips_cpu_harvard.sv
`timescale 1ns/1ns
`default_nettype none

module mips_cpu_harvard #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_0040
) (
	input  logic clk,
	input  logic reset,
	input  logic clk_enable,          // Low freezes the core
	output logic active,
	output logic [31:0] register_v0,

	output logic [31:0] instr_address, // Current PC
	input  logic [31:0] instr_readdata,  // Same-cycle fetch

	output logic [31:0] data_address,  // ALU result
	output logic data_write,
	output logic data_read,
	output logic [31:0] data_writedata,
	input  logic [31:0] data_readdata
);

	logic reg_write, reg_dst, alu_src, mem_to_reg;
	logic mem_write, mem_read;
	logic pc_src, jump, halt;
	logic zero, jump_target_zero;
	mips_ctrl_pkg::alu_op_t alu_op;

	mips_controller u_ctrl (
		.op               (instr_readdata[mips_isa_pkg::OP_HI:mips_isa_pkg::OP_LO]),
		.funct            (instr_readdata[mips_isa_pkg::FN_HI:mips_isa_pkg::FN_LO]),
		.zero             (zero),
		.jump_target_zero (jump_target_zero),
		.reg_write        (reg_write),
		.reg_dst          (reg_dst),
		.alu_src          (alu_src),
		.mem_to_reg       (mem_to_reg),
		.mem_write        (mem_write),
		.mem_read         (mem_read),
		.pc_src           (pc_src),
		.jump             (jump),
		.halt             (halt),
		.alu_op           (alu_op)
	);

	mips_datapath #(
		.RESET_VECTOR (RESET_VECTOR)
	) u_datapath (
		.clk              (clk),
		.reset            (reset),
		.clk_enable       (clk_enable),
		.instr            (instr_readdata),
		.reg_write        (reg_write),
		.reg_dst          (reg_dst),
		.alu_src          (alu_src),
		.mem_to_reg       (mem_to_reg),
		.pc_src           (pc_src),
		.jump             (jump),
		.halt             (halt),
		.alu_op           (alu_op),
		.read_data        (data_readdata),
		.pc               (instr_address),
		.alu_result       (data_address),
		.write_data       (data_writedata),
		.zero             (zero),
		.jump_target_zero (jump_target_zero),
		.v0               (register_v0),
		.active           (active)
	);

	// No memory traffic in reset or once halted
	assign data_write = mem_write & active & ~reset;
	assign data_read  = mem_read & active & ~reset;

endmodule

`default_nettype wire

//--- logic/mips_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module mips_datapath #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_0040
) (
	input  logic clk,
	input  logic reset,
	input  logic clk_enable,
	input  logic [31:0] instr,
	input  logic reg_write,
	input  logic reg_dst,
	input  logic alu_src,
	input  logic mem_to_reg,
	input  logic pc_src,
	input  logic jump,
	input  logic halt,
	input  mips_ctrl_pkg::alu_op_t alu_op,
	input  logic [31:0] read_data,
	output logic [31:0] pc,
	output logic [31:0] alu_result,
	output logic [31:0] write_data,
	output logic zero,
	output logic jump_target_zero,
	output logic [31:0] v0,
	output logic active
);

	logic retire; // Instruction completes on this edge
	logic [31:0] pc_plus4, pc_next;
	logic [31:0] branch_target, jump_target;
	logic [15:0] imm;
	logic [31:0] sign_imm;
	logic [4:0] rs, rt, rd, write_reg;
	logic [31:0] src_a, src_b;
	logic [31:0] result;

	// Instruction fields
	assign rs  = instr[mips_isa_pkg::RS_HI:mips_isa_pkg::RS_LO];
	assign rt  = instr[mips_isa_pkg::RT_HI:mips_isa_pkg::RT_LO];
	assign rd  = instr[mips_isa_pkg::RD_HI:mips_isa_pkg::RD_LO];
	assign imm = instr[mips_isa_pkg::IMM_HI:mips_isa_pkg::IMM_LO];
	assign sign_imm = {{16{imm[15]}}, imm};

	// Next PC candidates
	assign pc_plus4      = pc + 32'd4;
	assign branch_target = pc_plus4 + {sign_imm[29:0], 2'b00}; // Word offset from PC+4
	assign jump_target   = {pc_plus4[31:28],
		instr[mips_isa_pkg::TGT_HI:mips_isa_pkg::TGT_LO], 2'b00}; // Same 256 MB region
	assign jump_target_zero = (jump_target == 32'd0);

	always_comb begin
		if (jump) pc_next = jump_target;
		else if (pc_src) pc_next = branch_target;
		else pc_next = pc_plus4;
	end

	assign retire = clk_enable & active;

	// PC and run flag
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc     <= RESET_VECTOR;
			active <= 1'b1;
		end else if (retire) begin
			if (halt) active <= 1'b0; // PC stays on the J 0
			else pc <= pc_next;
		end
	end

	assign write_reg = reg_dst ? rd : rt;   // R-type uses rd
	assign result    = mem_to_reg ? read_data : alu_result;

	mips_regfile u_regfile (
		.clk   (clk),
		.reset (reset),
		.we    (reg_write & retire),
		.ra1   (rs),
		.ra2   (rt),
		.wa    (write_reg),
		.wd    (result),
		.rd1   (src_a),
		.rd2   (write_data), // rt also feeds the store data
		.v0    (v0)
	);

	assign src_b = alu_src ? sign_imm : write_data; // Immediate for I-type

	mips_alu u_alu (
		.a    (src_a),
		.b    (src_b),
		.op   (alu_op),
		.y    (alu_result),
		.zero (zero)
	);

endmodule

`default_nettype wire

//--- logic/mips_alu.sv
`timescale 1ns/1ns
`default_nettype none

module mips_alu (
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  mips_ctrl_pkg::alu_op_t op,
	output logic [31:0] y,
	output logic zero
);

	always_comb begin
		case (op)
			mips_ctrl_pkg::ALU_AND: y = a & b;
			mips_ctrl_pkg::ALU_OR:  y = a | b;
			mips_ctrl_pkg::ALU_ADD: y = a + b; // Overflow ignored
			mips_ctrl_pkg::ALU_SUB: y = a - b;
			mips_ctrl_pkg::ALU_SLT: begin
				// Two's complement compare
				y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			end
			default: y = '0; // Unused encodings
		endcase
	end

	assign zero = (y == 32'd0); // Feeds BEQ decision

endmodule

`default_nettype wire

//--- logic/mips_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module mips_regfile (
	input  logic clk,
	input  logic reset,
	input  logic we,         // Already qualified by stall and active
	input  logic [4:0] ra1,
	input  logic [4:0] ra2,
	input  logic [4:0] wa,
	input  logic [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2,
	output logic [31:0] v0   // Debug view of $v0
);

	logic [31:0] rf [32];

	// Whole array cleared on reset
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				rf[i] <= '0;
			end
		end else if (we && (wa != 5'd0)) begin // $zero never written
			rf[wa] <= wd;
		end
	end

	// Two read ports, no bypass
	assign rd1 = rf[ra1];
	assign rd2 = rf[ra2];
	assign v0  = rf[mips_isa_pkg::REG_V0];

endmodule

`default_nettype wire

//--- logic/mips_controller.sv
`timescale 1ns/1ns
`default_nettype none

module mips_controller (
	input  logic [5:0] op,
	input  logic [5:0] funct,
	input  logic zero,             // ALU result was zero
	input  logic jump_target_zero, // Computed J target is address 0
	output logic reg_write,
	output logic reg_dst,
	output logic alu_src,
	output logic mem_to_reg,
	output logic mem_write,
	output logic mem_read,
	output logic pc_src,
	output logic jump,
	output logic halt,
	output mips_ctrl_pkg::alu_op_t alu_op
);

	logic branch;
	mips_ctrl_pkg::alu_class_t alu_class; // Main decoder to ALU decoder

	mips_main_decoder u_main_dec (
		.op         (op),
		.reg_write  (reg_write),
		.reg_dst    (reg_dst),
		.alu_src    (alu_src),
		.branch     (branch),
		.mem_write  (mem_write),
		.mem_read   (mem_read),
		.mem_to_reg (mem_to_reg),
		.jump       (jump),
		.alu_class  (alu_class)
	);

	mips_alu_decoder u_alu_dec (
		.funct     (funct),
		.alu_class (alu_class),
		.alu_op    (alu_op)
	);

	assign pc_src = branch & zero; // BEQ taken
	assign halt   = jump & jump_target_zero; // J 0 stops the core

endmodule

`default_nettype wire

//--- logic/mips_alu_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module mips_alu_decoder (
	input  logic [5:0] funct,
	input  mips_ctrl_pkg::alu_class_t alu_class,
	output mips_ctrl_pkg::alu_op_t alu_op
);

	// Second level of decode
	always_comb begin
		case (alu_class)
			mips_ctrl_pkg::CLS_ADD: alu_op = mips_ctrl_pkg::ALU_ADD;
			mips_ctrl_pkg::CLS_SUB: alu_op = mips_ctrl_pkg::ALU_SUB;
			mips_ctrl_pkg::CLS_FUNCT: begin
				case (funct)
					mips_isa_pkg::FN_ADD: alu_op = mips_ctrl_pkg::ALU_ADD;
					mips_isa_pkg::FN_SUB: alu_op = mips_ctrl_pkg::ALU_SUB;
					mips_isa_pkg::FN_AND: alu_op = mips_ctrl_pkg::ALU_AND;
					mips_isa_pkg::FN_OR:  alu_op = mips_ctrl_pkg::ALU_OR;
					mips_isa_pkg::FN_SLT: alu_op = mips_ctrl_pkg::ALU_SLT;
					default:              alu_op = mips_ctrl_pkg::ALU_ADD; // Unsupported funct
				endcase
			end
			default: alu_op = mips_ctrl_pkg::ALU_ADD; // Class 2'b11 never issued
		endcase
	end

endmodule

`default_nettype wire

//--- logic/mips_main_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module mips_main_decoder (
	input  logic [5:0] op,
	output logic reg_write,
	output logic reg_dst,
	output logic alu_src,
	output logic branch,
	output logic mem_write,
	output logic mem_read,
	output logic mem_to_reg,
	output logic jump,
	output mips_ctrl_pkg::alu_class_t alu_class
);

	always_comb begin
		// Everything off unless the opcode says otherwise
		reg_write  = 1'b0;
		reg_dst    = 1'b0;
		alu_src    = 1'b0;
		branch     = 1'b0;
		mem_write  = 1'b0;
		mem_read   = 1'b0;
		mem_to_reg = 1'b0;
		jump       = 1'b0;
		alu_class  = mips_ctrl_pkg::CLS_ADD;
		case (op)
			mips_isa_pkg::OP_RTYPE: begin
				reg_write = 1'b1;
				reg_dst   = 1'b1; // Write rd
				alu_class = mips_ctrl_pkg::CLS_FUNCT;
			end
			mips_isa_pkg::OP_LW: begin
				reg_write  = 1'b1;
				alu_src    = 1'b1; // Base plus offset
				mem_read   = 1'b1;
				mem_to_reg = 1'b1; // Load result into rt
			end
			mips_isa_pkg::OP_SW: begin
				alu_src   = 1'b1;
				mem_write = 1'b1;
			end
			mips_isa_pkg::OP_BEQ: begin
				branch    = 1'b1;
				alu_class = mips_ctrl_pkg::CLS_SUB; // rs - rt, zero means equal
			end
			mips_isa_pkg::OP_ADDI: begin
				reg_write = 1'b1;
				alu_src   = 1'b1;
			end
			mips_isa_pkg::OP_J: jump = 1'b1;
			default: ; // Unknown opcode retires as a no-op
		endcase
	end

endmodule

`default_nettype wire

//--- logic/mips_ctrl_pkg.sv
`default_nettype none

package mips_ctrl_pkg;

	// ALU operation select
	// Codes kept close to the classic single-cycle table
	typedef enum logic [2:0] {
		ALU_AND = 3'b000,
		ALU_OR  = 3'b001,
		ALU_ADD = 3'b010, // Also address calc for LW and SW
		ALU_SUB = 3'b110, // Used for BEQ compare
		ALU_SLT = 3'b111  // Signed set-less-than
	} alu_op_t;

	// Coarse ALU class from the main decoder
	// The ALU decoder turns it into a real operation
	typedef enum logic [1:0] {
		CLS_ADD   = 2'b00, // LW, SW, ADDI
		CLS_SUB   = 2'b01, // BEQ
		CLS_FUNCT = 2'b10  // R-type, look at funct
	} alu_class_t;

endpackage

`default_nettype wire

//--- logic/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

	// Primary opcodes in bits 31:26
	localparam logic [5:0] OP_RTYPE = 6'b000000; // Operation picked by funct
	localparam logic [5:0] OP_LW    = 6'b100011;
	localparam logic [5:0] OP_SW    = 6'b101011;
	localparam logic [5:0] OP_BEQ   = 6'b000100;
	localparam logic [5:0] OP_ADDI  = 6'b001000;
	localparam logic [5:0] OP_J     = 6'b000010;

	// R-type funct codes
	localparam logic [5:0] FN_ADD = 6'b100000;
	localparam logic [5:0] FN_SUB = 6'b100010;
	localparam logic [5:0] FN_AND = 6'b100100;
	localparam logic [5:0] FN_OR  = 6'b100101;
	localparam logic [5:0] FN_SLT = 6'b101010; // Signed compare

	localparam logic [4:0] REG_V0 = 5'd2; // Return value register, shown on debug port

	// Bit positions inside the instruction word
	localparam int OP_HI  = 31;
	localparam int OP_LO  = 26;
	localparam int RS_HI  = 25; // First source
	localparam int RS_LO  = 21;
	localparam int RT_HI  = 20; // Second source or I-type destination
	localparam int RT_LO  = 16;
	localparam int RD_HI  = 15; // R-type destination
	localparam int RD_LO  = 11;
	localparam int FN_HI  = 5;
	localparam int FN_LO  = 0;
	localparam int IMM_HI = 15; // 16-bit immediate, also sign bit
	localparam int IMM_LO = 0;
	localparam int TGT_HI = 25; // 26-bit word index for J
	localparam int TGT_LO = 0;

endpackage

`default_nettype wire
